//--- la_id_pkg.sv
package la_id_pkg;

    localparam int XLEN     = 32;  // data and address width
    localparam int REG_AW   = 5;
    localparam int NUM_REGS = 32;
    localparam int LINK_REG = 1;   // bl writes its return address here

    // alu operation handed to ex
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_nor,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_e;

    // branch kind resolved in id
    typedef enum logic [3:0] {
        br_none,
        br_beq,
        br_bne,
        br_blt,
        br_bge,
        br_bltu,
        br_bgeu,
        br_b,
        br_bl,
        br_jirl
    } br_kind_e;

    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word
    } mem_size_e;

    typedef struct packed {
        logic [XLEN-1:0] inst;
        logic [XLEN-1:0] pc;
    } if_to_id_t;

    // redirect back to fetch
    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } br_bus_t;

    typedef struct packed {
        logic              we;
        logic [REG_AW-1:0] waddr;
        logic [XLEN-1:0]   wdata;
    } rf_write_t;

    // one producer further down the pipe
    typedef struct packed {
        rf_write_t wr;
        logic      pending;  // wdata not computed yet
    } fwd_src_t;

    typedef struct packed {
        alu_op_e           alu_op;
        br_kind_e          br_kind;
        logic [XLEN-1:0]   imm;
        logic [XLEN-1:0]   offs;         // branch offset, already <<2
        logic              src1_is_pc;
        logic              src2_is_imm;
        logic [REG_AW-1:0] raddr1;
        logic [REG_AW-1:0] raddr2;
        logic              need_r1;
        logic              need_r2;
        logic              rf_we;
        logic [REG_AW-1:0] rf_waddr;
        logic              mem_we;
        logic              res_from_mem;
        mem_size_e         mem_size;
        logic              mem_unsigned;
    } dec_t;

    typedef struct packed {
        alu_op_e           alu_op;
        logic [XLEN-1:0]   src1;
        logic [XLEN-1:0]   src2;
        logic              rf_we;
        logic [REG_AW-1:0] rf_waddr;
        logic              mem_we;
        logic              res_from_mem;
        mem_size_e         mem_size;
        logic              mem_unsigned;
        logic [XLEN-1:0]   store_data;
        logic [XLEN-1:0]   pc;
    } id_to_ex_t;

endpackage

//--- id_decoder.sv
module id_decoder (
    input  logic [la_id_pkg::XLEN-1:0] inst,
    output la_id_pkg::dec_t            dec
);
    import la_id_pkg::*;

    logic [5:0]        op_31_26;
    logic [3:0]        op_25_22;
    logic [1:0]        op_21_20;
    logic [4:0]        op_19_15;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rj;
    logic [REG_AW-1:0] rk;
    logic [11:0]       i12;
    logic [19:0]       i20;
    logic [15:0]       i16;
    logic [25:0]       i26;

    logic [XLEN-1:0]   si12;
    logic [XLEN-1:0]   ui12;
    logic [XLEN-1:0]   si20;

    logic              r3_hit;     // three-register alu group
    alu_op_e           r3_op;
    logic              sh_hit;     // shift by ui5
    alu_op_e           sh_op;
    logic              ri_hit;     // 2ri12 alu group
    alu_op_e           ri_op;
    logic              ri_zext;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];
    assign rd       = inst[4:0];
    assign rj       = inst[9:5];
    assign rk       = inst[14:10];
    assign i12      = inst[21:10];
    assign i20      = inst[24:5];
    assign i16      = inst[25:10];
    assign i26      = {inst[9:0], inst[25:10]};

    assign si12 = {{20{i12[11]}}, i12};  // ui5 shifts take the low bits of this
    assign ui12 = {20'b0, i12};
    assign si20 = {i20, 12'b0};

    always_comb begin
        r3_hit = (op_31_26 == 6'h00) && (op_25_22 == 4'h0) && (op_21_20 == 2'h1);
        r3_op  = alu_add;
        case (op_19_15)
            5'h00: r3_op = alu_add;
            5'h02: r3_op = alu_sub;
            5'h04: r3_op = alu_slt;
            5'h05: r3_op = alu_sltu;
            5'h08: r3_op = alu_nor;
            5'h09: r3_op = alu_and;
            5'h0a: r3_op = alu_or;
            5'h0b: r3_op = alu_xor;
            5'h0e: r3_op = alu_sll;
            5'h0f: r3_op = alu_srl;
            5'h10: r3_op = alu_sra;
            default: r3_hit = 1'b0;  // includes mul/div space
        endcase
    end

    always_comb begin
        sh_hit = (op_31_26 == 6'h00) && (op_25_22 == 4'h1) && (op_21_20 == 2'h0);
        sh_op  = alu_sll;
        case (op_19_15)
            5'h01: sh_op = alu_sll;
            5'h09: sh_op = alu_srl;
            5'h11: sh_op = alu_sra;
            default: sh_hit = 1'b0;
        endcase
    end

    always_comb begin
        ri_hit  = (op_31_26 == 6'h00);
        ri_op   = alu_add;
        ri_zext = 1'b0;
        case (op_25_22)
            4'h8: ri_op = alu_slt;
            4'h9: ri_op = alu_sltu;
            4'ha: ri_op = alu_add;
            4'hd: begin
                ri_op   = alu_and;
                ri_zext = 1'b1;
            end
            4'he: begin
                ri_op   = alu_or;
                ri_zext = 1'b1;
            end
            4'hf: begin
                ri_op   = alu_xor;
                ri_zext = 1'b1;
            end
            default: ri_hit = 1'b0;
        endcase
    end

    always_comb begin
        dec          = '0;       // unknown encodings stay a bubble
        dec.alu_op   = alu_add;
        dec.br_kind  = br_none;
        dec.mem_size = size_word;
        dec.raddr1   = rj;
        dec.raddr2   = rk;
        dec.rf_waddr = rd;
        dec.offs     = (op_31_26 == 6'h14 || op_31_26 == 6'h15) ?
                       {{4{i26[25]}}, i26, 2'b0} : {{14{i16[15]}}, i16, 2'b0};

        if (r3_hit) begin
            dec.alu_op  = r3_op;
            dec.need_r1 = 1'b1;
            dec.need_r2 = 1'b1;
            dec.rf_we   = 1'b1;
        end else if (sh_hit || ri_hit) begin
            dec.alu_op      = sh_hit ? sh_op : ri_op;
            dec.imm         = ri_zext ? ui12 : si12;
            dec.src2_is_imm = 1'b1;
            dec.need_r1     = 1'b1;
            dec.rf_we       = 1'b1;
        end else begin
            case (op_31_26)
                6'h05, 6'h07: if (!inst[25]) begin  // lu12i / pcaddu12i
                    dec.alu_op      = (op_31_26 == 6'h05) ? alu_lui : alu_add;
                    dec.src1_is_pc  = (op_31_26 == 6'h07);
                    dec.imm         = si20;
                    dec.src2_is_imm = 1'b1;
                    dec.rf_we       = 1'b1;
                end
                6'h0a: begin
                    dec.imm          = si12;
                    dec.src2_is_imm  = 1'b1;
                    dec.mem_unsigned = op_25_22[3];
                    dec.mem_size     = (op_25_22[1:0] == 2'd0) ? size_byte :
                                       (op_25_22[1:0] == 2'd1) ? size_half : size_word;
                    case (op_25_22)
                        4'h0, 4'h1, 4'h2, 4'h8, 4'h9: begin  // loads
                            dec.need_r1      = 1'b1;
                            dec.rf_we        = 1'b1;
                            dec.res_from_mem = 1'b1;
                        end
                        4'h4, 4'h5, 4'h6: begin  // stores read rd as data
                            dec.raddr2  = rd;
                            dec.need_r1 = 1'b1;
                            dec.need_r2 = 1'b1;
                            dec.mem_we  = 1'b1;
                        end
                        default: dec.src2_is_imm = 1'b0;
                    endcase
                end
                6'h13: begin
                    dec.br_kind     = br_jirl;
                    dec.src1_is_pc  = 1'b1;
                    dec.imm         = 32'd4;  // link value pc+4
                    dec.src2_is_imm = 1'b1;
                    dec.need_r1     = 1'b1;
                    dec.rf_we       = 1'b1;
                end
                6'h14: dec.br_kind = br_b;
                6'h15: begin
                    dec.br_kind     = br_bl;
                    dec.src1_is_pc  = 1'b1;
                    dec.imm         = 32'd4;
                    dec.src2_is_imm = 1'b1;
                    dec.rf_we       = 1'b1;
                    dec.rf_waddr    = REG_AW'(LINK_REG);
                end
                6'h16, 6'h17, 6'h18, 6'h19, 6'h1a, 6'h1b: begin
                    dec.br_kind = (op_31_26 == 6'h16) ? br_beq  :
                                  (op_31_26 == 6'h17) ? br_bne  :
                                  (op_31_26 == 6'h18) ? br_blt  :
                                  (op_31_26 == 6'h19) ? br_bge  :
                                  (op_31_26 == 6'h1a) ? br_bltu : br_bgeu;
                    dec.raddr2  = rd;    // compare rj against rd
                    dec.need_r1 = 1'b1;
                    dec.need_r2 = 1'b1;
                end
                default: ;
            endcase
        end
    end

endmodule

//--- id_regfile.sv
module id_regfile (
    input  logic                         clk,
    input  logic [la_id_pkg::REG_AW-1:0] raddr1,
    input  logic [la_id_pkg::REG_AW-1:0] raddr2,
    input  la_id_pkg::rf_write_t         wr,
    output logic [la_id_pkg::XLEN-1:0]   rdata1,
    output logic [la_id_pkg::XLEN-1:0]   rdata2
);
    import la_id_pkg::*;

    logic [XLEN-1:0] rf [NUM_REGS];

    // r0 is never written
    always_ff @(posedge clk) begin
        if (wr.we && wr.waddr != '0) begin
            rf[wr.waddr] <= wr.wdata;
        end
    end

    // async read with r0 tied to zero
    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

//--- id_hazard_unit.sv
module id_hazard_unit (
    input  logic [la_id_pkg::REG_AW-1:0] raddr1,
    input  logic [la_id_pkg::REG_AW-1:0] raddr2,
    input  logic                         need_r1,
    input  logic                         need_r2,
    input  logic [la_id_pkg::XLEN-1:0]   rdata1,
    input  logic [la_id_pkg::XLEN-1:0]   rdata2,
    input  la_id_pkg::fwd_src_t          ex_fwd,
    input  la_id_pkg::fwd_src_t          mem_fwd,
    input  la_id_pkg::rf_write_t         wb_wr,
    output logic [la_id_pkg::XLEN-1:0]   rj_value,
    output logic [la_id_pkg::XLEN-1:0]   rkd_value,
    output logic                         stall
);
    import la_id_pkg::*;

    logic [REG_AW-1:0] src_addr  [2];
    logic              src_need  [2];
    logic [XLEN-1:0]   src_rdata [2];
    logic [XLEN-1:0]   src_value [2];
    logic [1:0]        hit_ex;
    logic [1:0]        hit_mem;
    logic [1:0]        hit_wb;

    // producer writes the register this source actually reads
    function automatic logic producer_hit(input rf_write_t wr,
                                          input logic [REG_AW-1:0] addr,
                                          input logic need);
        return need && wr.we && (addr != '0) && (wr.waddr == addr);
    endfunction

    assign src_addr[0]  = raddr1;
    assign src_addr[1]  = raddr2;
    assign src_need[0]  = need_r1;
    assign src_need[1]  = need_r2;
    assign src_rdata[0] = rdata1;
    assign src_rdata[1] = rdata2;

    always_comb begin
        stall = 1'b0;
        for (int i = 0; i < 2; i++) begin
            hit_ex[i]  = producer_hit(ex_fwd.wr, src_addr[i], src_need[i]);
            hit_mem[i] = producer_hit(mem_fwd.wr, src_addr[i], src_need[i]);
            hit_wb[i]  = producer_hit(wb_wr, src_addr[i], src_need[i]);

            // youngest producer wins
            if (hit_ex[i]) begin
                src_value[i] = ex_fwd.wr.wdata;
                stall        = stall | ex_fwd.pending;
            end else if (hit_mem[i]) begin
                src_value[i] = mem_fwd.wr.wdata;
                stall        = stall | mem_fwd.pending;
            end else if (hit_wb[i]) begin
                src_value[i] = wb_wr.wdata;  // also covers same-cycle rf write
            end else begin
                src_value[i] = src_rdata[i];
            end
        end
    end

    assign rj_value  = src_value[0];
    assign rkd_value = src_value[1];

endmodule

//--- id_branch_unit.sv
module id_branch_unit (
    input  la_id_pkg::br_kind_e        br_kind,
    input  logic [la_id_pkg::XLEN-1:0] pc,
    input  logic [la_id_pkg::XLEN-1:0] offs,
    input  logic [la_id_pkg::XLEN-1:0] rj_value,
    input  logic [la_id_pkg::XLEN-1:0] rkd_value,
    output logic                       cond,
    output logic [la_id_pkg::XLEN-1:0] target
);
    import la_id_pkg::*;

    logic            rj_eq_rd;
    logic            rj_lt_rd;
    logic            rj_ltu_rd;
    logic [XLEN-1:0] base;

    assign rj_eq_rd  = (rj_value == rkd_value);
    assign rj_lt_rd  = ($signed(rj_value) < $signed(rkd_value));
    assign rj_ltu_rd = (rj_value < rkd_value);

    always_comb begin
        case (br_kind)
            br_beq:  cond = rj_eq_rd;
            br_bne:  cond = !rj_eq_rd;
            br_blt:  cond = rj_lt_rd;
            br_bge:  cond = !rj_lt_rd;
            br_bltu: cond = rj_ltu_rd;
            br_bgeu: cond = !rj_ltu_rd;
            br_b, br_bl, br_jirl: cond = 1'b1;  // unconditional
            default: cond = 1'b0;
        endcase
    end

    // jirl is register relative and the rest pc relative
    assign base   = (br_kind == br_jirl) ? rj_value : pc;
    assign target = base + offs;

endmodule

//--- id_stage.sv
module id_stage (
    input  logic                   clk,
    input  logic                   resetn,

    // fetch side
    input  logic                   if_valid,
    input  la_id_pkg::if_to_id_t   if_bus,
    output logic                   id_allowin,
    output la_id_pkg::br_bus_t     br_bus,

    // ex side
    output logic                   ex_valid,
    output la_id_pkg::id_to_ex_t   ex_bus,
    input  logic                   ex_allowin,

    // forwarding producers plus the wb regfile write
    input  la_id_pkg::fwd_src_t    ex_fwd,
    input  la_id_pkg::fwd_src_t    mem_fwd,
    input  la_id_pkg::rf_write_t   wb_wr
);
    import la_id_pkg::*;

    logic            id_valid;
    if_to_id_t       id_reg;      // inst/pc held in the stage
    dec_t            dec;

    logic [XLEN-1:0] rf_rdata1;
    logic [XLEN-1:0] rf_rdata2;
    logic [XLEN-1:0] rj_value;
    logic [XLEN-1:0] rkd_value;
    logic            stall;
    logic            ready_go;
    logic            br_cond;
    logic            br_taken;
    logic [XLEN-1:0] br_target;

    assign ready_go   = ~stall;
    assign id_allowin = ~id_valid | (ready_go & ex_allowin);
    assign ex_valid   = id_valid & ready_go;

    // redirect only when the branch really moves on to ex
    assign br_taken = ex_valid & ex_allowin & br_cond;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
        end else if (br_taken) begin
            id_valid <= 1'b0;      // drop the fetch offered this cycle
        end else if (id_allowin) begin
            id_valid <= if_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (if_valid && id_allowin) begin
            id_reg <= if_bus;
        end
    end

    id_decoder u_decoder (
        .inst (id_reg.inst),
        .dec  (dec)
    );

    id_regfile u_regfile (
        .clk    (clk),
        .raddr1 (dec.raddr1),
        .raddr2 (dec.raddr2),
        .wr     (wb_wr),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    id_hazard_unit u_hazard (
        .raddr1    (dec.raddr1),
        .raddr2    (dec.raddr2),
        .need_r1   (dec.need_r1),
        .need_r2   (dec.need_r2),
        .rdata1    (rf_rdata1),
        .rdata2    (rf_rdata2),
        .ex_fwd    (ex_fwd),
        .mem_fwd   (mem_fwd),
        .wb_wr     (wb_wr),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .stall     (stall)
    );

    id_branch_unit u_branch (
        .br_kind   (dec.br_kind),
        .pc        (id_reg.pc),
        .offs      (dec.offs),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .cond      (br_cond),
        .target    (br_target)
    );

    assign br_bus = '{taken: br_taken, target: br_target};

    always_comb begin
        ex_bus.alu_op       = dec.alu_op;
        ex_bus.src1         = dec.src1_is_pc ? id_reg.pc : rj_value;
        ex_bus.src2         = dec.src2_is_imm ? dec.imm : rkd_value;
        ex_bus.rf_we        = dec.rf_we & id_valid;  // side effects only when valid
        ex_bus.rf_waddr     = dec.rf_waddr;
        ex_bus.mem_we       = dec.mem_we & id_valid;
        ex_bus.res_from_mem = dec.res_from_mem & id_valid;
        ex_bus.mem_size     = dec.mem_size;
        ex_bus.mem_unsigned = dec.mem_unsigned;
        ex_bus.store_data   = rkd_value;
        ex_bus.pc           = id_reg.pc;
    end

endmodule

//--- id_stage_tb.sv
module id_stage_tb;
    import la_id_pkg::*;

    localparam int PERIOD   = 20;
    localparam int N_ALU    = 200;
    localparam int N_FWD    = 150;
    localparam int N_STALL  = 40;
    localparam int N_BR     = 120;
    localparam int N_MEM    = 80;
    localparam int N_BP     = 40;
    localparam int MAX_WAIT = 20;  // cycles one instruction may sit in id
    localparam int N_INST   = N_ALU + N_FWD + N_STALL + N_BR + N_MEM + N_BP;
    localparam int WATCHDOG_CYCLES = N_INST * (MAX_WAIT + 4) + 200;

    logic      clk;
    logic      resetn;
    logic      if_valid;
    if_to_id_t if_bus;
    logic      id_allowin;
    br_bus_t   br_bus;
    logic      ex_valid;
    id_to_ex_t ex_bus;
    logic      ex_allowin;
    fwd_src_t  ex_fwd;
    fwd_src_t  mem_fwd;
    rf_write_t wb_wr;

    integer      seed = 32'h4f67573b;
    logic [31:0] regs [32];        // shadow of the register file
    logic        m_valid;          // model of the stage contents
    logic [31:0] m_inst;
    logic [31:0] m_pc;
    id_to_ex_t   exp_bus;
    br_bus_t     exp_br;
    logic        exp_exv;
    logic        exp_allowin;
    rf_write_t   wb_late;          // wb write driven once the instruction sits in id

    id_stage u_id_stage (
        .clk        (clk),
        .resetn     (resetn),
        .if_valid   (if_valid),
        .if_bus     (if_bus),
        .id_allowin (id_allowin),
        .br_bus     (br_bus),
        .ex_valid   (ex_valid),
        .ex_bus     (ex_bus),
        .ex_allowin (ex_allowin),
        .ex_fwd     (ex_fwd),
        .mem_fwd    (mem_fwd),
        .wb_wr      (wb_wr)
    );

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    task automatic check(input string what, input logic [159:0] got, input logic [159:0] exp);
        if (got !== exp) begin
            $display("ERR @%0t: %s mismatch, got %h expected %h", $time, what, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // youngest matching producer wins and r0 or unused sources never forward
    function automatic logic [31:0] operand(input logic [4:0] a, input logic need,
                                            output logic wait_fwd);
        wait_fwd = 1'b0;
        if (need && a != 0 && ex_fwd.wr.we && ex_fwd.wr.waddr == a) begin
            wait_fwd = ex_fwd.pending;
            return ex_fwd.wr.wdata;
        end
        if (need && a != 0 && mem_fwd.wr.we && mem_fwd.wr.waddr == a) begin
            wait_fwd = mem_fwd.pending;
            return mem_fwd.wr.wdata;
        end
        if (need && a != 0 && wb_wr.we && wb_wr.waddr == a) return wb_wr.wdata;
        return (a == 0) ? 32'd0 : regs[a];
    endfunction

    function automatic void ref_model();
        logic [31:0] i;
        logic [31:0] imm;
        logic [31:0] si12;
        logic [31:0] offs;
        logic [31:0] v1;
        logic [31:0] v2;
        logic [4:0]  ra2;
        logic        r3;
        logic        sh;
        logic        ri;
        logic        zext;
        logic        n1;
        logic        n2;
        logic        s1pc;
        logic        s2imm;
        logic        we;
        logic        st1;
        logic        st2;
        logic        cond;
        logic        stall;
        alu_op_e     op;
        br_kind_e    bk;
        i = m_inst;
        exp_bus = '0;
        exp_bus.mem_size = size_word;
        exp_bus.rf_waddr = i[4:0];
        ra2 = i[14:10];
        {zext, n1, n2, s1pc, s2imm, we} = '0;
        imm = '0;
        si12 = {{20{i[21]}}, i[21:10]};
        op = alu_add;
        bk = br_none;
        r3 = 1'b1;
        case (i[31:15])
            17'h00020: op = alu_add;
            17'h00022: op = alu_sub;
            17'h00024: op = alu_slt;
            17'h00025: op = alu_sltu;
            17'h00028: op = alu_nor;
            17'h00029: op = alu_and;
            17'h0002a: op = alu_or;
            17'h0002b: op = alu_xor;
            17'h0002e: op = alu_sll;
            17'h0002f: op = alu_srl;
            17'h00030: op = alu_sra;
            default: r3 = 1'b0;
        endcase
        sh = 1'b1;
        case (i[31:15])
            17'h00081: op = alu_sll;
            17'h00089: op = alu_srl;
            17'h00091: op = alu_sra;
            default: sh = 1'b0;
        endcase
        ri = 1'b1;
        case (i[31:22])
            10'h008: op = alu_slt;
            10'h009: op = alu_sltu;
            10'h00a: op = alu_add;
            10'h00d: begin
                op = alu_and;
                zext = 1'b1;
            end
            10'h00e: begin
                op = alu_or;
                zext = 1'b1;
            end
            10'h00f: begin
                op = alu_xor;
                zext = 1'b1;
            end
            default: ri = 1'b0;
        endcase
        if (r3) begin
            {n1, n2, we} = 3'b111;
        end else if (sh || ri) begin
            {n1, we, s2imm} = 3'b111;
            imm = zext ? {20'b0, i[21:10]} : si12;
        end else begin
            case (i[31:26])
                6'h05, 6'h07: if (!i[25]) begin
                    op = (i[27]) ? alu_add : alu_lui;  // pcaddu12i adds to pc
                    s1pc = i[27];
                    {we, s2imm} = 2'b11;
                    imm = {i[24:5], 12'b0};
                end
                6'h0a: begin
                    exp_bus.mem_size = (i[23:22] == 0) ? size_byte :
                                       (i[23:22] == 1) ? size_half : size_word;
                    exp_bus.mem_unsigned = i[25];
                    {n1, s2imm} = 2'b11;
                    imm = si12;
                    if (i[24]) begin
                        n2 = 1'b1;
                        ra2 = i[4:0];  // store data from rd
                        exp_bus.mem_we = 1'b1;
                    end else begin
                        we = 1'b1;
                        exp_bus.res_from_mem = 1'b1;
                    end
                end
                6'h13: begin
                    bk = br_jirl;
                    {s1pc, s2imm, n1, we} = 4'b1111;
                    imm = 32'd4;
                end
                6'h14: bk = br_b;
                6'h15: begin
                    bk = br_bl;
                    {s1pc, s2imm, we} = 3'b111;
                    imm = 32'd4;
                    exp_bus.rf_waddr = 5'(LINK_REG);
                end
                6'h16, 6'h17, 6'h18, 6'h19, 6'h1a, 6'h1b: begin
                    bk = br_kind_e'(i[29:26] - 4'h5);  // beq..bgeu in order
                    {n1, n2} = 2'b11;
                    ra2 = i[4:0];
                end
                default: ;
            endcase
        end
        if (bk == br_b || bk == br_bl) offs = {{4{i[9]}}, i[9:0], i[25:10], 2'b0};
        else offs = {{14{i[25]}}, i[25:10], 2'b0};
        v1 = operand(i[9:5], n1, st1);
        v2 = operand(ra2, n2, st2);
        stall = st1 | st2;
        case (bk)
            br_beq:  cond = (v1 == v2);
            br_bne:  cond = (v1 != v2);
            br_blt:  cond = ($signed(v1) < $signed(v2));
            br_bge:  cond = ($signed(v1) >= $signed(v2));
            br_bltu: cond = (v1 < v2);
            br_bgeu: cond = (v1 >= v2);
            br_b, br_bl, br_jirl: cond = 1'b1;
            default: cond = 1'b0;
        endcase
        exp_exv = m_valid & ~stall;
        exp_allowin = ~m_valid | (~stall & ex_allowin);
        exp_br.taken = exp_exv & ex_allowin & cond;
        exp_br.target = ((bk == br_jirl) ? v1 : m_pc) + offs;
        exp_bus.alu_op = op;
        exp_bus.src1 = s1pc ? m_pc : v1;
        exp_bus.src2 = s2imm ? imm : v2;
        exp_bus.rf_we = we & m_valid;
        exp_bus.mem_we = exp_bus.mem_we & m_valid;
        exp_bus.res_from_mem = exp_bus.res_from_mem & m_valid;
        exp_bus.store_data = v2;
        exp_bus.pc = m_pc;
    endfunction

    // compare before the edge takes effect, then advance the model
    always @(posedge clk) begin
        if (!resetn) begin
            m_valid = 1'b0;
        end else begin
            ref_model();
            check("ex_valid", ex_valid, exp_exv);
            check("id_allowin", id_allowin, exp_allowin);
            check("br_bus.taken", br_bus.taken, exp_br.taken);
            if (m_valid) begin
                check("br_bus.target", br_bus.target, exp_br.target);
                check("ex_bus", ex_bus, exp_bus);
            end
            if (if_valid && exp_allowin) {m_inst, m_pc} = if_bus;
            if (exp_br.taken) m_valid = 1'b0;
            else if (exp_allowin) m_valid = if_valid;
            if (wb_wr.we && wb_wr.waddr != 0) regs[wb_wr.waddr] = wb_wr.wdata;
        end
    end

    function automatic logic [31:0] rand_alu();
        logic [31:0] r;
        r = $random(seed);
        case ({$random(seed)} % 22)
            0: return {17'h00020, r[14:0]};
            1: return {17'h00022, r[14:0]};
            2: return {17'h00024, r[14:0]};
            3: return {17'h00025, r[14:0]};
            4: return {17'h00028, r[14:0]};
            5: return {17'h00029, r[14:0]};
            6: return {17'h0002a, r[14:0]};
            7: return {17'h0002b, r[14:0]};
            8: return {17'h0002e, r[14:0]};
            9: return {17'h0002f, r[14:0]};
            10: return {17'h00030, r[14:0]};
            11: return {17'h00081, r[14:0]};
            12: return {17'h00089, r[14:0]};
            13: return {17'h00091, r[14:0]};
            14: return {10'h008, r[21:0]};
            15: return {10'h009, r[21:0]};
            16: return {10'h00a, r[21:0]};
            17: return {10'h00d, r[21:0]};
            18: return {10'h00e, r[21:0]};
            19: return {10'h00f, r[21:0]};
            20: return {7'h0a, r[24:0]};
            default: return {7'h0e, r[24:0]};
        endcase
    endfunction

    function automatic logic [31:0] rand_mem();
        logic [31:0] r;
        logic [9:0]  ops [8];
        r = $random(seed);
        ops = '{10'h0a0, 10'h0a1, 10'h0a2, 10'h0a8, 10'h0a9, 10'h0a4, 10'h0a5, 10'h0a6};
        return {ops[{$random(seed)} % 8], r[21:0]};
    endfunction

    function automatic logic [31:0] rand_br();
        logic [31:0] r;
        r = $random(seed);
        if (r[31:30] == 0) r[4:0] = r[9:5];  // equal operands now and then
        return {6'h13 + 6'({$random(seed)} % 9), r[25:0]};
    endfunction

    function automatic fwd_src_t pick_src(input logic [31:0] inst);
        logic [31:0] r;
        fwd_src_t    s;
        r = $random(seed);
        s.wr.we = r[0];
        case (r[2:1])
            0: s.wr.waddr = inst[9:5];
            1: s.wr.waddr = inst[14:10];
            2: s.wr.waddr = inst[4:0];
            default: s.wr.waddr = r[7:3];  // may be r0
        endcase
        s.wr.wdata = $random(seed);
        s.pending = 1'b0;
        return s;
    endfunction

    task automatic quiet_fwd();
        @(negedge clk);
        if_valid = 1'b0;
        ex_fwd = '0;
        mem_fwd = '0;
        wb_wr = '0;
        wb_late = '0;
    endtask

    task automatic rand_fwd(input logic [31:0] inst);
        fwd_src_t w;
        @(negedge clk);
        if_valid = 1'b0;
        ex_fwd = pick_src(inst);
        mem_fwd = pick_src(inst);
        w = pick_src(inst);
        wb_wr = '0;
        wb_late = w.wr;  // regfile still holds the old value when this is used
    endtask

    task automatic offer(input logic [31:0] inst);
        logic took;
        took = 1'b0;
        while (!took) begin
            @(negedge clk);
            if_valid = 1'b1;
            if_bus.inst = inst;
            if_bus.pc = $random(seed) & 32'hffff_fffc;
            #1 took = id_allowin;
            @(posedge clk);
        end
    endtask

    // wait until ex takes the instruction
    // pending and back-pressure drop after a few cycles and junk offers a fetch meanwhile
    task automatic wait_issue(input int release_at, input int bp_cycles, input logic junk);
        int   n;
        logic done;
        n = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            wb_wr = wb_late;
            if (n >= release_at) begin
                ex_fwd.pending = 1'b0;
                mem_fwd.pending = 1'b0;
            end
            ex_allowin = (n >= bp_cycles);
            if_valid = junk;
            if (junk) if_bus = {rand_alu(), $random(seed) & 32'hffff_fffc};
            #1 done = ex_valid && ex_allowin;
            n++;
            if (n > MAX_WAIT) begin
                $display("instruction was never handed to ex");
                $display("Test failed");
                $fatal(1);
            end
            @(posedge clk);
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("watchdog expired, the run did not finish in time");
        $display("Test failed");
        $fatal(1);
    end

    initial begin
        logic [31:0] inst;
        fwd_src_t    p;
        resetn = 1'b0;
        if_valid = 1'b0;
        if_bus = '0;
        ex_allowin = 1'b1;
        ex_fwd = '0;
        mem_fwd = '0;
        wb_wr = '0;
        wb_late = '0;
        m_valid = 1'b0;
        regs[0] = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        for (int r = 1; r < 32; r++) begin  // preload through the wb port
            @(negedge clk);
            wb_wr = '{we: 1'b1, waddr: 5'(r), wdata: $random(seed)};
        end
        for (int k = 0; k < N_ALU; k++) begin
            quiet_fwd();
            offer(rand_alu());
            wait_issue(0, 0, 1'b0);
        end
        for (int k = 0; k < N_FWD; k++) begin
            inst = (k % 3 == 0) ? rand_alu() : (k % 3 == 1) ? rand_mem() : rand_br();
            rand_fwd(inst);
            offer(inst);
            wait_issue(0, 0, 1'b0);
        end
        for (int k = 0; k < N_STALL; k++) begin
            inst = $random(seed);
            inst[31:15] = 17'h00020;  // add.w reading a pending rj
            inst[9:5] = 5'(1 + {$random(seed)} % 31);
            quiet_fwd();
            p = '{wr: '{we: 1'b1, waddr: inst[9:5], wdata: $random(seed)}, pending: 1'b1};
            if (k % 2) ex_fwd = p;
            else mem_fwd = p;
            offer(inst);
            wait_issue(1 + {$random(seed)} % 4, 0, 1'b0);
        end
        for (int k = 0; k < N_BR; k++) begin
            inst = rand_br();
            rand_fwd(inst);
            offer(inst);
            wait_issue(0, 0, 1'b1);
        end
        for (int k = 0; k < N_MEM; k++) begin
            quiet_fwd();
            offer(rand_mem());
            wait_issue(0, 0, 1'b0);
        end
        for (int k = 0; k < N_BP; k++) begin
            quiet_fwd();
            offer((k % 2) ? rand_br() : rand_alu());
            wait_issue(0, 1 + {$random(seed)} % 5, k % 2);
        end
        quiet_fwd();
        repeat (5) @(posedge clk);
        $display("Test passed");
        $finish;
    end

endmodule

//--- la_id_stage.f
la_id_pkg.sv
id_decoder.sv
id_regfile.sv
id_hazard_unit.sv
id_branch_unit.sv
id_stage.sv
id_stage_tb.sv
